//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/register_file.sv
verilog/decoder.sv
verilog/load_store_unit.sv
verilog/core_top.sv
sim/core_asserts.sv
sim/core_tb.sv

//--- sim/core_asserts.sv
`timescale 1ns/1ps

module core_asserts (
  input logic                clk,
  input logic                reset,
  input rv_isa_pkg::word_t   pc,
  input core_pkg::dmem_req_t dmem_req,
  input logic                halt
);

  no_write_in_reset_or_halt: assert property (
    @(posedge clk) (reset || halt) |-> !dmem_req.write
  ) else $error("memory write issued while reset or halt is high");

  wmask_needs_write: assert property (
    @(posedge clk) !dmem_req.write |-> (dmem_req.wmask == '0)
  ) else $error("wmask not zero without a write");

  no_access_on_halt: assert property (
    @(posedge clk) halt |-> !(dmem_req.read || dmem_req.write)
  ) else $error("memory access while halted");

  pc_bit0_clear: assert property (
    @(posedge clk) disable iff (reset) !pc[0]  // jump targets drop bit 0
  ) else $error("pc bit 0 set");

endmodule

bind core_top core_asserts u_asserts (
  .clk      (clk),
  .reset    (reset),
  .pc       (pc),
  .dmem_req (dmem_req),
  .halt     (halt)
);

//--- sim/core_tb.sv
`timescale 1ns/1ps

module core_tb;

  localparam logic [31:0] seed_init    = 32'h627d_f995;
  localparam int          reset_cycles = 4;
  localparam int          num_insts    = 1500;  // retired before ebreak is fetched
  localparam int          hold_cycles  = 40;    // halt must hold this long
  localparam int          max_cycles   = reset_cycles + num_insts + hold_cycles + 56;
  // cumulative opcode mix out of 100 with raw random words above the last
  localparam int          w_addi  = 24;
  localparam int          w_lui   = 32;
  localparam int          w_auipc = 39;
  localparam int          w_load  = 62;
  localparam int          w_store = 86;
  localparam int          w_jal   = 91;
  localparam int          w_jalr  = 96;

  logic                  clk = 1'b0;
  logic                  reset = 1'b1;
  rv_isa_pkg::word_t     inst;
  rv_isa_pkg::word_t     pc;
  core_pkg::dmem_req_t   dmem_req;
  rv_isa_pkg::word_t     dmem_rdata;
  logic                  halt;

  integer                seed = seed_init;
  int                    cycle = 0;
  int                    retired = 0;
  int                    generated = 0;
  int                    hold_count = 0;
  int                    pc_errors = 0;
  int                    req_errors = 0;
  int                    halt_errors = 0;
  int                    run_errors = 0;
  logic                  rst_next;

  rv_isa_pkg::word_t     imem [rv_isa_pkg::word_t];  // filled on first fetch
  rv_isa_pkg::word_t     dmem [rv_isa_pkg::word_t];  // written words only
  rv_isa_pkg::word_t     regs [0:31];
  rv_isa_pkg::word_t     m_pc;
  rv_isa_pkg::word_t     cur_inst;
  rv_isa_pkg::word_t     exp_next_pc;
  rv_isa_pkg::word_t     exp_wb;
  logic                  exp_wr;
  logic                  exp_halt;
  core_pkg::dmem_req_t   exp_req;

  always #4 clk = ~clk;

  core_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .pc         (pc),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  // background for words never stored
  function automatic rv_isa_pkg::word_t fill_word(rv_isa_pkg::word_t addr);
    return ({addr[31:2], 2'b00} * 32'h9e37_79b9) ^ 32'h5bd1_e995;
  endfunction

  function automatic rv_isa_pkg::word_t read_word(rv_isa_pkg::word_t addr);
    rv_isa_pkg::word_t key;
    key = {addr[31:2], 2'b00};
    if (dmem.exists(key)) return dmem[key];
    return fill_word(key);
  endfunction

  function automatic rv_isa_pkg::word_t gen_inst();
    rv_isa_pkg::word_t r;
    int                pick;
    int                sel;
    logic [2:0]        f3;
    r    = $random(seed);
    pick = $unsigned($random(seed)) % 100;
    sel  = $unsigned($random(seed)) % 5;
    f3   = (sel < 3) ? 3'(sel) : 3'(sel + 1);  // lb lh lw lbu lhu
    generated++;
    if (generated <= 31) begin
      // seed x1..x31 with small values so addresses overlap
      return {r[31:20], 5'd0, 3'b000, 5'(generated), rv_isa_pkg::op_imm};
    end
    if (pick < w_addi) return {r[31:15], 3'b000, r[11:7], rv_isa_pkg::op_imm};
    if (pick < w_lui) return {r[31:7], rv_isa_pkg::lui};
    if (pick < w_auipc) return {r[31:7], rv_isa_pkg::auipc};
    if (pick < w_load) return {r[31:15], f3, r[11:7], rv_isa_pkg::load};
    if (pick < w_store) return {r[31:15], 3'(sel % 3), r[11:7], rv_isa_pkg::store};
    if (pick < w_jal) return {r[31:7], rv_isa_pkg::jal};
    if (pick < w_jalr) return {r[31:15], 3'b000, r[11:7], rv_isa_pkg::jalr};
    return r;  // mostly unknown opcodes
  endfunction

  function automatic rv_isa_pkg::word_t fetch(rv_isa_pkg::word_t addr);
    if (retired >= num_insts) return rv_isa_pkg::ebreak_inst;
    if (!imem.exists(addr)) imem[addr] = gen_inst();
    return imem[addr];
  endfunction

  // expected outputs and effects of cur_inst
  task automatic predict(input logic in_reset);
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t addr;
    rv_isa_pkg::word_t w;
    rv_isa_pkg::word_t sh_w;
    rv_isa_pkg::word_t imm_i;
    logic [2:0]        f3;
    logic [1:0]        off;
    a     = regs[cur_inst[19:15]];
    b     = regs[cur_inst[24:20]];
    f3    = cur_inst[14:12];
    imm_i = {{20{cur_inst[31]}}, cur_inst[31:20]};
    exp_req     = '0;
    exp_wr      = 1'b0;
    exp_wb      = '0;
    exp_halt    = 1'b0;
    exp_next_pc = m_pc + 32'd4;
    case (rv_isa_pkg::opcode_e'(cur_inst[6:0]))
      rv_isa_pkg::op_imm: begin
        exp_wr = (f3 == 3'b000);
        exp_wb = a + imm_i;
      end
      rv_isa_pkg::lui: begin
        exp_wr = 1'b1;
        exp_wb = {cur_inst[31:12], 12'h000};
      end
      rv_isa_pkg::auipc: begin
        exp_wr = 1'b1;
        exp_wb = m_pc + {cur_inst[31:12], 12'h000};
      end
      rv_isa_pkg::jal: begin
        exp_wr      = 1'b1;
        exp_wb      = m_pc + 32'd4;
        exp_next_pc = m_pc + {{12{cur_inst[31]}}, cur_inst[19:12], cur_inst[20],
                              cur_inst[30:21], 1'b0};
      end
      rv_isa_pkg::jalr: begin
        exp_wr      = 1'b1;
        exp_wb      = m_pc + 32'd4;
        exp_next_pc = (a + imm_i) & ~32'h1;
      end
      rv_isa_pkg::load: begin
        if (f3 != 3'b011 && f3[2:1] != 2'b11) begin
          addr = a + imm_i;
          off  = addr[1:0];
          w    = read_word(addr);
          sh_w = w >> {off, 3'b000};
          exp_req.addr = addr;
          exp_req.read = 1'b1;
          exp_wr       = 1'b1;
          case (f3)
            3'b000:  exp_wb = {{24{sh_w[7]}}, sh_w[7:0]};
            3'b100:  exp_wb = {24'h0, sh_w[7:0]};
            3'b001:  exp_wb = off[0] ? '0 : {{16{sh_w[15]}}, sh_w[15:0]};
            3'b101:  exp_wb = off[0] ? '0 : {16'h0, sh_w[15:0]};
            default: exp_wb = (off == 2'b00) ? w : '0;
          endcase
        end
      end
      rv_isa_pkg::store: begin
        if (f3[2] == 1'b0 && f3[1:0] != 2'b11) begin
          addr = a + {{20{cur_inst[31]}}, cur_inst[31:25], cur_inst[11:7]};
          off  = addr[1:0];
          exp_req.addr  = addr;
          exp_req.write = 1'b1;
          case (f3)
            3'b000: begin
              exp_req.wdata = {4{b[7:0]}};
              exp_req.wmask = 4'b0001 << off;
            end
            3'b001: begin
              exp_req.wdata = {2{b[15:0]}};
              exp_req.wmask = off[0] ? 4'b0000 : (4'b0011 << off);
            end
            default: begin
              exp_req.wdata = b;
              exp_req.wmask = (off == 2'b00) ? 4'b1111 : 4'b0000;
            end
          endcase
        end
      end
      rv_isa_pkg::system: exp_halt = (cur_inst == rv_isa_pkg::ebreak_inst);
      default: ;
    endcase
    if (exp_halt) exp_next_pc = m_pc;
    if (in_reset) begin
      exp_req.read  = 1'b0;
      exp_req.write = 1'b0;
      exp_req.wmask = '0;
    end
  endtask

  task automatic retire();
    rv_isa_pkg::word_t key;
    rv_isa_pkg::word_t w;
    int                i;
    if (exp_wr && cur_inst[11:7] != 5'd0) regs[cur_inst[11:7]] = exp_wb;
    if (exp_req.write) begin
      key = {exp_req.addr[31:2], 2'b00};
      w   = read_word(key);
      for (i = 0; i < 4; i++) begin
        if (exp_req.wmask[i]) w[8*i +: 8] = exp_req.wdata[8*i +: 8];
      end
      dmem[key] = w;
    end
    m_pc = exp_next_pc;
    retired++;
  endtask

  task automatic check_pc(input rv_isa_pkg::word_t expected, input rv_isa_pkg::word_t actual);
    if (actual !== expected) begin
      $display("error at %0t: pc expected %h got %h", $time, expected, actual);
      pc_errors++;
    end
  endtask

  task automatic check_req(input core_pkg::dmem_req_t expected,
                           input core_pkg::dmem_req_t actual);
    if (actual.read !== expected.read || actual.write !== expected.write) begin
      $display("error at %0t: dmem_req read/write expected %b/%b got %b/%b", $time,
               expected.read, expected.write, actual.read, actual.write);
      req_errors++;
    end
    if (actual.wmask !== expected.wmask) begin
      $display("error at %0t: dmem_req.wmask expected %b got %b", $time,
               expected.wmask, actual.wmask);
      req_errors++;
    end
    if ((expected.read || expected.write) && actual.addr !== expected.addr) begin
      $display("error at %0t: dmem_req.addr expected %h got %h", $time,
               expected.addr, actual.addr);
      req_errors++;
    end
    if (expected.write && actual.wdata !== expected.wdata) begin
      $display("error at %0t: dmem_req.wdata expected %h got %h", $time,
               expected.wdata, actual.wdata);
      req_errors++;
    end
  endtask

  task automatic check_halt(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error at %0t: halt expected %b got %b", $time, expected, actual);
      halt_errors++;
    end
  endtask

  // model steps on the same edge as the DUT and drives the next inputs
  always @(posedge clk) begin
    if (!reset) retire();
    rst_next = (cycle + 1 < reset_cycles);
    reset <= rst_next;
    cur_inst = fetch(m_pc);
    predict(rst_next);
    inst       <= cur_inst;
    dmem_rdata <= read_word(exp_req.addr);
    cycle = cycle + 1;
  end

  initial begin
    regs[0]  = '0;
    m_pc     = rv_isa_pkg::reset_vector;
    cur_inst = fetch(m_pc);
    predict(1'b1);
    inst       = cur_inst;
    dmem_rdata = read_word(exp_req.addr);
    while (cycle < max_cycles && hold_count < hold_cycles) begin
      @(negedge clk);  // outputs settled mid cycle
      check_pc(m_pc, pc);
      check_req(exp_req, dmem_req);
      check_halt(exp_halt, halt);
      if (exp_halt && halt === 1'b1) hold_count++;
    end
    if (hold_count < hold_cycles) begin
      $display("timeout: halt not held for %0d cycles within %0d cycles",
               hold_cycles, max_cycles);
      run_errors++;
    end
    $display("errors: pc %0d, dmem_req %0d, halt %0d, run %0d (retired %0d)",
             pc_errors, req_errors, halt_errors, run_errors, retired);
    if (pc_errors + req_errors + halt_errors + run_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

  localparam int strb_w = rv_isa_pkg::xlen / 8;  // one mask bit per byte lane

  // first operand of the shared adder
  typedef enum logic [1:0] {
    a_rs1,
    a_pc,
    a_zero
  } a_sel_e;

  // register write-back source
  typedef enum logic [1:0] {
    wb_sum,
    wb_pc_plus4,
    wb_load
  } wb_sel_e;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  jump;
    logic                  halt;
    a_sel_e                a_sel;
    wb_sel_e               wb_sel;
    rv_isa_pkg::mem_size_e size;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::word_t     imm;   // already sign-extended
  } ctrl_t;

  // data memory request, read data comes back in the same cycle
  typedef struct packed {
    rv_isa_pkg::word_t   addr;
    rv_isa_pkg::word_t   wdata;   // store bytes replicated into lanes
    logic [strb_w-1:0]   wmask;
    logic                read;
    logic                write;
  } dmem_req_t;

endpackage

//--- verilog/core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic                clk,
  input  logic                reset,
  input  rv_isa_pkg::word_t   inst,
  output rv_isa_pkg::word_t   pc,
  output core_pkg::dmem_req_t dmem_req,
  input  rv_isa_pkg::word_t   dmem_rdata,
  output logic                halt
);

  core_pkg::ctrl_t   ctrl;
  rv_isa_pkg::word_t rs1_data;
  rv_isa_pkg::word_t rs2_data;
  rv_isa_pkg::word_t op_a;
  rv_isa_pkg::word_t sum;
  rv_isa_pkg::word_t pc_plus4;
  rv_isa_pkg::word_t next_pc;
  rv_isa_pkg::word_t wb_data;
  rv_isa_pkg::word_t load_data;
  logic              reg_write;
  logic              mem_read;
  logic              mem_write;

  decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  // nothing architectural changes while in reset
  assign reg_write = ctrl.reg_write & ~reset;
  assign mem_read  = ctrl.mem_read & ~reset;
  assign mem_write = ctrl.mem_write & ~reset;

  register_file u_regs (
    .clk    (clk),
    .write  (reg_write),
    .waddr  (ctrl.rd),
    .raddr1 (ctrl.rs1),
    .raddr2 (ctrl.rs2),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  always_comb begin
    case (ctrl.a_sel)
      core_pkg::a_rs1: op_a = rs1_data;
      core_pkg::a_pc:  op_a = pc;
      default:         op_a = '0;  // lui
    endcase
  end

  // one adder for addresses, jump targets and results
  assign sum      = op_a + ctrl.imm;
  assign pc_plus4 = pc + 32'd4;

  load_store_unit u_lsu (
    .addr       (sum),
    .store_data (rs2_data),
    .size       (ctrl.size),
    .read       (mem_read),
    .write      (mem_write),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data)
  );

  always_comb begin
    case (ctrl.wb_sel)
      core_pkg::wb_pc_plus4: wb_data = pc_plus4;   // jal/jalr link
      core_pkg::wb_load:     wb_data = load_data;
      default:               wb_data = sum;
    endcase
  end

  assign halt = ctrl.halt;

  always_comb begin
    if (ctrl.halt) begin
      next_pc = pc;                  // hold on ebreak
    end else if (ctrl.jump) begin
      next_pc = {sum[31:1], 1'b0};   // jalr clears bit 0
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rv_isa_pkg::reset_vector;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  rv_isa_pkg::word_t inst,
  output core_pkg::ctrl_t   ctrl
);

  rv_isa_pkg::opcode_e   opcode;
  rv_isa_pkg::mem_size_e size;
  rv_isa_pkg::word_t     imm_i;
  rv_isa_pkg::word_t     imm_s;
  rv_isa_pkg::word_t     imm_u;
  rv_isa_pkg::word_t     imm_j;
  logic                  load_size_ok;
  logic                  store_size_ok;

  assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign size   = rv_isa_pkg::mem_size_e'(inst[14:12]);

  // immediates, all sign-extended from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};  // already shifted by 12
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // stores have no unsigned widths
  always_comb begin
    load_size_ok  = 1'b0;
    store_size_ok = 1'b0;
    case (size)
      rv_isa_pkg::size_byte,
      rv_isa_pkg::size_half,
      rv_isa_pkg::size_word: begin
        load_size_ok  = 1'b1;
        store_size_ok = 1'b1;
      end
      rv_isa_pkg::size_byte_u,
      rv_isa_pkg::size_half_u: load_size_ok = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    ctrl        = '0;           // unknown opcode, all enables low
    ctrl.a_sel  = core_pkg::a_zero;
    ctrl.wb_sel = core_pkg::wb_sum;
    ctrl.size   = size;
    ctrl.rd     = inst[11:7];
    ctrl.rs1    = inst[19:15];
    ctrl.rs2    = inst[24:20];
    ctrl.imm    = imm_i;

    case (opcode)
      rv_isa_pkg::op_imm: begin
        if (inst[14:12] == rv_isa_pkg::funct3_addi) begin
          ctrl.reg_write = 1'b1;
          ctrl.a_sel     = core_pkg::a_rs1;
        end
      end
      rv_isa_pkg::lui: begin
        ctrl.reg_write = 1'b1;  // 0 + imm
        ctrl.imm       = imm_u;
      end
      rv_isa_pkg::auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_sel     = core_pkg::a_pc;
        ctrl.imm       = imm_u;
      end
      rv_isa_pkg::jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.a_sel     = core_pkg::a_pc;
        ctrl.wb_sel    = core_pkg::wb_pc_plus4;
        ctrl.imm       = imm_j;
      end
      rv_isa_pkg::jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.a_sel     = core_pkg::a_rs1;
        ctrl.wb_sel    = core_pkg::wb_pc_plus4;
      end
      rv_isa_pkg::load: begin
        if (load_size_ok) begin
          ctrl.reg_write = 1'b1;
          ctrl.mem_read  = 1'b1;
          ctrl.a_sel     = core_pkg::a_rs1;
          ctrl.wb_sel    = core_pkg::wb_load;
        end
      end
      rv_isa_pkg::store: begin
        if (store_size_ok) begin
          ctrl.mem_write = 1'b1;
          ctrl.a_sel     = core_pkg::a_rs1;
          ctrl.imm       = imm_s;
        end
      end
      rv_isa_pkg::system: ctrl.halt = (inst == rv_isa_pkg::ebreak_inst);
      default: ;
    endcase
  end

endmodule

//--- verilog/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  rv_isa_pkg::word_t     addr,
  input  rv_isa_pkg::word_t     store_data,
  input  rv_isa_pkg::mem_size_e size,
  input  logic                  read,
  input  logic                  write,
  output core_pkg::dmem_req_t   dmem_req,
  input  rv_isa_pkg::word_t     dmem_rdata,
  output rv_isa_pkg::word_t     load_data
);

  logic [1:0]                  offset;
  logic                        aligned;
  logic [core_pkg::strb_w-1:0] mask;
  rv_isa_pkg::word_t           lanes;
  logic [7:0]                  byte_sel;
  logic [15:0]                 half_sel;

  assign offset = addr[1:0];

  // per-size mask, lane data and alignment
  always_comb begin
    aligned = 1'b0;
    mask    = '0;
    lanes   = store_data;
    case (size)
      rv_isa_pkg::size_byte, rv_isa_pkg::size_byte_u: begin
        aligned = 1'b1;
        mask    = 4'b0001 << offset;
        lanes   = {4{store_data[7:0]}};
      end
      rv_isa_pkg::size_half, rv_isa_pkg::size_half_u: begin
        aligned = ~offset[0];
        mask    = 4'b0011 << offset;
        lanes   = {2{store_data[15:0]}};
      end
      rv_isa_pkg::size_word: begin
        aligned = (offset == 2'b00);
        mask    = 4'b1111;
      end
      default: ;
    endcase
  end

  assign dmem_req.addr  = addr;
  assign dmem_req.wdata = lanes;
  assign dmem_req.wmask = (write && aligned) ? mask : '0;
  assign dmem_req.read  = read;
  assign dmem_req.write = write;

  assign byte_sel = dmem_rdata[8*offset +: 8];
  assign half_sel = offset[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    load_data = '0;  // also the misaligned result
    if (aligned) begin
      case (size)
        rv_isa_pkg::size_byte:   load_data = {{24{byte_sel[7]}}, byte_sel};
        rv_isa_pkg::size_byte_u: load_data = {24'h0, byte_sel};
        rv_isa_pkg::size_half:   load_data = {{16{half_sel[15]}}, half_sel};
        rv_isa_pkg::size_half_u: load_data = {16'h0, half_sel};
        rv_isa_pkg::size_word:   load_data = dmem_rdata;
        default: ;
      endcase
    end
  end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                  clk,
  input  logic                  write,
  input  rv_isa_pkg::reg_addr_t waddr,
  input  rv_isa_pkg::reg_addr_t raddr1,
  input  rv_isa_pkg::reg_addr_t raddr2,
  input  rv_isa_pkg::word_t     wdata,
  output rv_isa_pkg::word_t     rdata1,
  output rv_isa_pkg::word_t     rdata2
);

  // x0 has no storage
  rv_isa_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (write && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous reads
  always_comb begin
    rdata1 = '0;
    rdata2 = '0;
    if (raddr1 != '0) begin
      rdata1 = regs[raddr1];
    end
    if (raddr2 != '0) begin
      rdata2 = regs[raddr2];
    end
  end

endmodule

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int opcode_w   = 7;
  localparam int funct3_w   = 3;

  localparam logic [xlen-1:0] reset_vector = 32'h8000_0000;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // base opcodes of the supported subset, inst[6:0]
  typedef enum logic [opcode_w-1:0] {
    op_imm = 7'b001_0011,  // only addi is executed
    lui    = 7'b011_0111,
    auipc  = 7'b001_0111,
    jal    = 7'b110_1111,
    jalr   = 7'b110_0111,
    load   = 7'b000_0011,
    store  = 7'b010_0011,
    system = 7'b111_0011   // only ebreak is executed
  } opcode_e;

  // funct3 of loads and stores
  typedef enum logic [funct3_w-1:0] {
    size_byte   = 3'b000,
    size_half   = 3'b001,
    size_word   = 3'b010,
    size_byte_u = 3'b100,
    size_half_u = 3'b101
  } mem_size_e;

  localparam logic [funct3_w-1:0] funct3_addi = 3'b000;

  // full encoding, ecall and friends do not match
  localparam word_t ebreak_inst = 32'h0010_0073;

endpackage
